// File: filelist.f
src/rv_isa_pkg.sv
src/rv_ctrl_pkg.sv
src/rv_decode.sv
src/rv_regfile.sv
src/rv_execute.sv
src/rv_data_ram.sv
src/rv_result.sv
src/rv_core.sv
dv/rv_core_properties.sv
dv/rv_core_tb.sv

// File: Makefile
SIM        = verilator
TOP        = rv_core_tb
FILELIST   = filelist.f
SIM_FLAGS  = --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS = --lint-only -Wall --timing
OBJ_DIR    = obj_dir
LOG        = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^NO ERRORS$$" $(LOG)

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dv/rv_core_tb.sv
`timescale 1ns/1ps

module rv_core_tb;

        localparam int ROM_ADDR_W = 11;
        localparam int RAM_WORDS  = 256;
        localparam int WAIT_MAX   = 20;

        localparam logic [31:0] NOP = 32'h0000_0013; // addi x0,x0,0

        localparam logic [6:0] OPC_OP    = 7'h33;
        localparam logic [6:0] OPC_IMM   = 7'h13;
        localparam logic [6:0] OPC_LOAD  = 7'h03;
        localparam logic [6:0] OPC_STORE = 7'h23;
        localparam logic [6:0] OPC_BR    = 7'h63;
        localparam logic [6:0] OPC_LUI   = 7'h37;
        localparam logic [6:0] OPC_AUIPC = 7'h17;
        localparam logic [6:0] OPC_JAL   = 7'h6f;
        localparam logic [6:0] OPC_JALR  = 7'h67;

        logic                   clk;
        logic                   arst_n_i;
        logic [31:0]            inst_i;
        logic [ROM_ADDR_W-1:0]  rom_addr_o;
        logic                   store_en_o;
        logic [31:0]            store_addr_o;
        logic [31:0]            store_data_o;

        // trace table, one entry per executed instruction
        string                  name_q[$];
        logic [ROM_ADDR_W-1:0]  addr_q[$];
        logic [31:0]            inst_q[$];
        logic                   en_q[$];
        logic [31:0]            saddr_q[$];
        logic [31:0]            sdata_q[$];
        int                     errors;

        rv_core #(
                .ROM_ADDR_W (ROM_ADDR_W),
                .RAM_WORDS  (RAM_WORDS)
        ) u_rv_core (
                .clk          (clk),
                .arst_n_i     (arst_n_i),
                .inst_i       (inst_i),
                .rom_addr_o   (rom_addr_o),
                .store_en_o   (store_en_o),
                .store_addr_o (store_addr_o),
                .store_data_o (store_data_o)
        );

        always #2 clk = ~clk;

        function automatic logic [31:0] enc_r(input int f7, input int f3, input int rd,
                                              input int rs1, input int rs2);
                return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OPC_OP};
        endfunction

        function automatic logic [31:0] enc_i(input logic [6:0] op, input int f3, input int rd,
                                              input int rs1, input int imm);
                return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
        endfunction

        function automatic logic [31:0] enc_s(input int rs2, input int rs1, input int imm);
                return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], OPC_STORE};
        endfunction

        function automatic logic [31:0] enc_b(input int f3, input int rs1, input int rs2,
                                              input int imm);
                return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
                        OPC_BR};
        endfunction

        function automatic logic [31:0] enc_u(input logic [6:0] op, input int rd, input int imm);
                return {imm[19:0], rd[4:0], op};
        endfunction

        function automatic logic [31:0] enc_j(input int rd, input int imm);
                return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], OPC_JAL};
        endfunction

        task automatic add_store_row(input string name, input logic [31:0] pc,
                                     input logic [31:0] inst, input logic [31:0] saddr,
                                     input logic [31:0] sdata);
                name_q.push_back(name);
                addr_q.push_back(pc[ROM_ADDR_W+1:2]);
                inst_q.push_back(inst);
                en_q.push_back(1'b1);
                saddr_q.push_back(saddr);
                sdata_q.push_back(sdata);
        endtask

        task automatic add_row(input string name, input logic [31:0] pc, input logic [31:0] inst);
                add_store_row(name, pc, inst, '0, '0);
                en_q[en_q.size()-1] = 1'b0;
        endtask

        task automatic load_program();
                // x1 = 5, x2 = -3
                add_row("addi_pos", 'h00, enc_i(OPC_IMM, 0, 1, 0, 5));
                add_row("addi_neg", 'h04, enc_i(OPC_IMM, 0, 2, 0, -3));
                add_row("add", 'h08, enc_r(0, 0, 3, 1, 2));
                add_row("sub", 'h0c, enc_r('h20, 0, 4, 1, 2));
                add_store_row("sw_add", 'h10, enc_s(3, 0, 0), 'h00, 'h2);
                add_store_row("sw_sub", 'h14, enc_s(4, 0, 4), 'h04, 'h8);
                add_row("and", 'h18, enc_r(0, 7, 5, 1, 2));
                add_row("or", 'h1c, enc_r(0, 6, 6, 1, 2));
                add_row("xor", 'h20, enc_r(0, 4, 7, 1, 2));
                add_store_row("sw_and", 'h24, enc_s(5, 0, 8), 'h08, 'h5);
                add_store_row("sw_or", 'h28, enc_s(6, 0, 12), 'h0c, 'hffff_fffd);
                add_store_row("sw_xor", 'h2c, enc_s(7, 0, 16), 'h10, 'hffff_fff8);
                add_row("slt", 'h30, enc_r(0, 2, 8, 2, 1));
                add_row("sltu", 'h34, enc_r(0, 3, 9, 2, 1));
                add_store_row("sw_slt", 'h38, enc_s(8, 0, 20), 'h14, 'h1);
                add_store_row("sw_sltu", 'h3c, enc_s(9, 0, 24), 'h18, 'h0);
                add_row("sll", 'h40, enc_r(0, 1, 10, 1, 1));
                add_row("srl", 'h44, enc_r(0, 5, 11, 2, 1));
                add_row("sra", 'h48, enc_r('h20, 5, 12, 2, 1));
                add_store_row("sw_sll", 'h4c, enc_s(10, 0, 28), 'h1c, 'ha0);
                add_store_row("sw_srl", 'h50, enc_s(11, 0, 32), 'h20, 'h07ff_ffff);
                add_store_row("sw_sra", 'h54, enc_s(12, 0, 36), 'h24, 'hffff_ffff);
                // immediate chain on x13
                add_row("slli", 'h58, enc_i(OPC_IMM, 1, 13, 2, 4));
                add_row("srai", 'h5c, enc_i(OPC_IMM, 5, 13, 13, 'h402));
                add_row("srli", 'h60, enc_i(OPC_IMM, 5, 13, 13, 8));
                add_row("xori", 'h64, enc_i(OPC_IMM, 4, 13, 13, 'hf0));
                add_row("andi", 'h68, enc_i(OPC_IMM, 7, 13, 13, 'h7ff));
                add_row("ori", 'h6c, enc_i(OPC_IMM, 6, 13, 13, 'hf0));
                add_store_row("sw_imm_chain", 'h70, enc_s(13, 0, 40), 'h28, 'h7ff);
                add_row("slti", 'h74, enc_i(OPC_IMM, 2, 14, 2, -2));
                add_row("sltiu", 'h78, enc_i(OPC_IMM, 3, 15, 1, -1));
                add_store_row("sw_slti", 'h7c, enc_s(14, 0, 44), 'h2c, 'h1);
                add_store_row("sw_sltiu", 'h80, enc_s(15, 0, 48), 'h30, 'h1);
                add_row("lui", 'h84, enc_u(OPC_LUI, 16, 'h12345));
                add_row("auipc", 'h88, enc_u(OPC_AUIPC, 17, 1));
                add_store_row("sw_lui", 'h8c, enc_s(16, 0, 52), 'h34, 'h1234_5000);
                add_store_row("sw_auipc", 'h90, enc_s(17, 0, 56), 'h38, 'h1000 + 'h88);
                add_store_row("sw_before_lw", 'h94, enc_s(7, 0, 64), 'h40, 'hffff_fff8);
                add_row("lw", 'h98, enc_i(OPC_LOAD, 2, 18, 0, 64));
                add_store_row("sw_loaded", 'h9c, enc_s(18, 0, 68), 'h44, 'hffff_fff8);
                // branches skip one slot when taken
                add_row("beq_nt", 'ha0, enc_b(0, 1, 2, 8));
                add_row("beq_t", 'ha4, enc_b(0, 1, 1, 8));
                add_row("bne_nt", 'hac, enc_b(1, 1, 1, 8));
                add_row("bne_t", 'hb0, enc_b(1, 1, 2, 8));
                add_row("blt_nt", 'hb8, enc_b(4, 1, 2, 8));
                add_row("blt_t", 'hbc, enc_b(4, 2, 1, 8));
                add_row("bge_nt", 'hc4, enc_b(5, 2, 1, 8));
                add_row("bge_t", 'hc8, enc_b(5, 1, 2, 8));
                add_row("bltu_nt", 'hd0, enc_b(6, 2, 1, 8));
                add_row("bltu_t", 'hd4, enc_b(6, 1, 2, 8));
                add_row("bgeu_nt", 'hdc, enc_b(7, 1, 2, 8));
                add_row("bgeu_t", 'he0, enc_b(7, 2, 1, 8));
                add_row("jal", 'he8, enc_j(19, 16));
                add_store_row("sw_jal_link", 'hf8, enc_s(19, 0, 72), 'h48, 'hec);
                add_row("addi_jbase", 'hfc, enc_i(OPC_IMM, 0, 20, 0, 'h111));
                add_row("jalr", 'h100, enc_i(OPC_JALR, 0, 21, 20, 16)); // 0x121 -> 0x120
                add_store_row("sw_jalr_link", 'h120, enc_s(21, 0, 76), 'h4c, 'h104);
                add_row("addi_x0", 'h124, enc_i(OPC_IMM, 0, 0, 1, 7));
                add_store_row("sw_x0", 'h128, enc_s(0, 0, 80), 'h50, 'h0);
        endtask

        initial begin
                int cnt;

                errors   = 0;
                clk      = 1'b0;
                arst_n_i = 1'b0;
                inst_i   = NOP;
                load_program();

                repeat (4) @(posedge clk);
                #1;
                arst_n_i = 1'b1;

                cnt = 0;
                while ((arst_n_i !== 1'b1 || rom_addr_o !== '0) && cnt < WAIT_MAX) begin
                        @(posedge clk);
                        cnt++;
                end

                if (cnt >= WAIT_MAX) begin
                        errors++;
                        $display("reset release not seen within %0d cycles", WAIT_MAX);
                end else begin
                        for (int k = 0; k < inst_q.size(); k++) begin
                                if (rom_addr_o !== addr_q[k]) begin
                                        errors++;
                                        $display("Mismatch %s rom_addr: expected %h, actual %h",
                                                 name_q[k], addr_q[k], rom_addr_o);
                                end
                                inst_i = inst_q[k];
                                #1;
                                if (store_en_o !== en_q[k]) begin
                                        errors++;
                                        $display("Mismatch %s store_en: expected %b, actual %b",
                                                 name_q[k], en_q[k], store_en_o);
                                end
                                if (en_q[k] && store_addr_o !== saddr_q[k]) begin
                                        errors++;
                                        $display("Mismatch %s store_addr: expected %h, actual %h",
                                                 name_q[k], saddr_q[k], store_addr_o);
                                end
                                if (en_q[k] && store_data_o !== sdata_q[k]) begin
                                        errors++;
                                        $display("Mismatch %s store_data: expected %h, actual %h",
                                                 name_q[k], sdata_q[k], store_data_o);
                                end
                                @(posedge clk);
                                #1;
                        end
                        inst_i = NOP;
                end

                $display("errors: %0d", errors);
                if (errors == 0) begin
                        $display("NO ERRORS");
                end else begin
                        $display("ERRORS FOUND");
                end
                $finish;
        end

endmodule

// File: dv/rv_core_properties.sv
`timescale 1ns/1ps

module rv_core_properties #(
        parameter int ROM_ADDR_W = 11
) (
        input logic                     clk,
        input logic                     arst_n_i,
        input logic                     store_en_i,
        input logic [31:0]              store_addr_i,
        input logic [ROM_ADDR_W-1:0]    rom_addr_i
);

        store_aligned: assert property (@(posedge clk) disable iff (!arst_n_i)
                store_en_i |-> store_addr_i[1:0] == 2'b00)
                else $error("store address %h is not word aligned", store_addr_i);

        no_store_in_reset: assert property (@(posedge clk) !arst_n_i |-> !store_en_i)
                else $error("store enable high while reset is asserted");

        pc_held_in_reset: assert property (@(posedge clk) !arst_n_i |-> rom_addr_i == '0)
                else $error("rom address %h not zero during reset", rom_addr_i);

endmodule

bind rv_core rv_core_properties #(
        .ROM_ADDR_W (ROM_ADDR_W)
) u_properties (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .store_en_i   (store_en_o),
        .store_addr_i (store_addr_o),
        .rom_addr_i   (rom_addr_o)
);

// File: src/rv_core.sv
`timescale 1ns/1ps

module rv_core #(
        parameter int ROM_ADDR_W = 11,
        parameter int RAM_WORDS  = 256
) (
        input  logic                            clk,
        input  logic                            arst_n_i,
        input  logic [rv_isa_pkg::XLEN-1:0]     inst_i,
        output logic [ROM_ADDR_W-1:0]           rom_addr_o,
        output logic                            store_en_o,
        output logic [rv_isa_pkg::XLEN-1:0]     store_addr_o,
        output logic [rv_isa_pkg::XLEN-1:0]     store_data_o
);
        logic [4:0]                     rs1;
        logic [4:0]                     rs2;
        logic [4:0]                     rd;
        logic [rv_isa_pkg::XLEN-1:0]    imm;
        rv_ctrl_pkg::alu_op_e           alu_op;
        rv_ctrl_pkg::src_a_e            src_a;
        rv_ctrl_pkg::src_b_e            src_b;
        rv_ctrl_pkg::br_cond_e          br_cond;
        rv_ctrl_pkg::wb_sel_e           wb_sel;
        logic                           jump;
        logic                           mem_wr;
        logic                           reg_wr;
        logic [rv_isa_pkg::XLEN-1:0]    rs1_data;
        logic [rv_isa_pkg::XLEN-1:0]    rs2_data;
        logic [rv_isa_pkg::XLEN-1:0]    pc;
        logic [rv_isa_pkg::XLEN-1:0]    alu_result;
        logic                           take;
        logic [rv_isa_pkg::XLEN-1:0]    rdata;
        logic [rv_isa_pkg::XLEN-1:0]    wb_data;

        rv_decode u_decode (
                .inst_i    (inst_i),
                .rs1_o     (rs1),
                .rs2_o     (rs2),
                .rd_o      (rd),
                .imm_o     (imm),
                .alu_op_o  (alu_op),
                .src_a_o   (src_a),
                .src_b_o   (src_b),
                .br_cond_o (br_cond),
                .jump_o    (jump),
                .mem_wr_o  (mem_wr),
                .reg_wr_o  (reg_wr),
                .wb_sel_o  (wb_sel)
        );

        rv_regfile u_regfile (
                .clk        (clk),
                .arst_n_i   (arst_n_i),
                .rs1_i      (rs1),
                .rs2_i      (rs2),
                .rd_i       (rd),
                .wr_en_i    (reg_wr),
                .wr_data_i  (wb_data),
                .rs1_data_o (rs1_data),
                .rs2_data_o (rs2_data)
        );

        rv_execute u_execute (
                .pc_i         (pc),
                .rs1_data_i   (rs1_data),
                .rs2_data_i   (rs2_data),
                .imm_i        (imm),
                .alu_op_i     (alu_op),
                .src_a_i      (src_a),
                .src_b_i      (src_b),
                .br_cond_i    (br_cond),
                .jump_i       (jump),
                .alu_result_o (alu_result),
                .take_o       (take)
        );

        rv_data_ram #(
                .RAM_WORDS (RAM_WORDS)
        ) u_data_ram (
                .clk     (clk),
                .wr_en_i (mem_wr),
                .addr_i  (alu_result),
                .wdata_i (rs2_data),
                .rdata_o (rdata)
        );

        rv_result #(
                .ROM_ADDR_W (ROM_ADDR_W)
        ) u_result (
                .clk          (clk),
                .arst_n_i     (arst_n_i),
                .wb_sel_i     (wb_sel),
                .take_i       (take),
                .alu_result_i (alu_result),
                .mem_data_i   (rdata),
                .pc_o         (pc),
                .rom_addr_o   (rom_addr_o),
                .wb_data_o    (wb_data)
        );

        // store bus mirrors the ram write port
        assign store_en_o   = mem_wr;
        assign store_addr_o = alu_result;
        assign store_data_o = rs2_data;

endmodule

// File: src/rv_result.sv
`timescale 1ns/1ps

module rv_result #(
        parameter int ROM_ADDR_W = 11
) (
        input  logic                            clk,
        input  logic                            arst_n_i,
        input  rv_ctrl_pkg::wb_sel_e            wb_sel_i,
        input  logic                            take_i,
        input  logic [rv_isa_pkg::XLEN-1:0]     alu_result_i,
        input  logic [rv_isa_pkg::XLEN-1:0]     mem_data_i,
        output logic [rv_isa_pkg::XLEN-1:0]     pc_o,
        output logic [ROM_ADDR_W-1:0]           rom_addr_o,
        output logic [rv_isa_pkg::XLEN-1:0]     wb_data_o
);
        logic [rv_isa_pkg::XLEN-1:0] pc_q;
        logic [rv_isa_pkg::XLEN-1:0] pc_plus4;

        assign pc_plus4 = pc_q + 32'd4;

        always_ff @(posedge clk or negedge arst_n_i) begin
                if (!arst_n_i) begin
                        pc_q <= '0;
                end else begin
                        pc_q <= take_i ? alu_result_i : pc_plus4; // branch or jump target
                end
        end

        always_comb begin
                case (wb_sel_i)
                        rv_ctrl_pkg::WB_MEM: wb_data_o = mem_data_i;
                        rv_ctrl_pkg::WB_PC4: wb_data_o = pc_plus4; // link
                        default:             wb_data_o = alu_result_i;
                endcase
        end

        assign pc_o       = pc_q;
        assign rom_addr_o = pc_q[ROM_ADDR_W+1:2];

endmodule

// File: src/rv_data_ram.sv
`timescale 1ns/1ps

module rv_data_ram #(
        parameter int RAM_WORDS = 256
) (
        input  logic                            clk,
        input  logic                            wr_en_i,
        input  logic [rv_isa_pkg::XLEN-1:0]     addr_i,
        input  logic [rv_isa_pkg::XLEN-1:0]     wdata_i,
        output logic [rv_isa_pkg::XLEN-1:0]     rdata_o
);
        localparam int IDX_W = $clog2(RAM_WORDS);

        logic [rv_isa_pkg::XLEN-1:0] mem [RAM_WORDS];
        logic [IDX_W-1:0]            idx;

        assign idx = IDX_W'(addr_i[rv_isa_pkg::XLEN-1:2] % RAM_WORDS); // word index, wraps

        always_ff @(posedge clk) begin
                if (wr_en_i) begin
                        mem[idx] <= wdata_i;
                end
        end

        assign rdata_o = mem[idx]; // async read, lw same cycle

endmodule

// File: src/rv_execute.sv
`timescale 1ns/1ps

module rv_execute (
        input  logic [rv_isa_pkg::XLEN-1:0]     pc_i,
        input  logic [rv_isa_pkg::XLEN-1:0]     rs1_data_i,
        input  logic [rv_isa_pkg::XLEN-1:0]     rs2_data_i,
        input  logic [rv_isa_pkg::XLEN-1:0]     imm_i,
        input  rv_ctrl_pkg::alu_op_e            alu_op_i,
        input  rv_ctrl_pkg::src_a_e             src_a_i,
        input  rv_ctrl_pkg::src_b_e             src_b_i,
        input  rv_ctrl_pkg::br_cond_e           br_cond_i,
        input  logic                            jump_i,
        output logic [rv_isa_pkg::XLEN-1:0]     alu_result_o,
        output logic                            take_o
);
        localparam int XLEN = rv_isa_pkg::XLEN;

        logic [XLEN-1:0] op_a;
        logic [XLEN-1:0] op_b;
        logic [XLEN-1:0] alu;
        logic [4:0]      shamt;
        logic            cmp;

        assign op_a  = (src_a_i == rv_ctrl_pkg::SRC_A_PC)  ? pc_i  : rs1_data_i;
        assign op_b  = (src_b_i == rv_ctrl_pkg::SRC_B_IMM) ? imm_i : rs2_data_i;
        assign shamt = op_b[4:0];

        always_comb begin
                case (alu_op_i)
                        rv_ctrl_pkg::ALU_ADD:   alu = op_a + op_b;
                        rv_ctrl_pkg::ALU_SUB:   alu = op_a - op_b;
                        rv_ctrl_pkg::ALU_AND:   alu = op_a & op_b;
                        rv_ctrl_pkg::ALU_OR:    alu = op_a | op_b;
                        rv_ctrl_pkg::ALU_XOR:   alu = op_a ^ op_b;
                        rv_ctrl_pkg::ALU_SLT:   alu = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
                        rv_ctrl_pkg::ALU_SLTU:  alu = {{(XLEN-1){1'b0}}, op_a < op_b};
                        rv_ctrl_pkg::ALU_SLL:   alu = op_a << shamt;
                        rv_ctrl_pkg::ALU_SRL:   alu = op_a >> shamt;
                        rv_ctrl_pkg::ALU_SRA:   alu = $signed(op_a) >>> shamt;
                        rv_ctrl_pkg::ALU_PASSB: alu = op_b;
                        default:                alu = '0;
                endcase
        end

        always_comb begin
                case (br_cond_i)
                        rv_ctrl_pkg::BR_EQ:  cmp = rs1_data_i == rs2_data_i;
                        rv_ctrl_pkg::BR_NE:  cmp = rs1_data_i != rs2_data_i;
                        rv_ctrl_pkg::BR_LT:  cmp = $signed(rs1_data_i) < $signed(rs2_data_i);
                        rv_ctrl_pkg::BR_GE:  cmp = $signed(rs1_data_i) >= $signed(rs2_data_i);
                        rv_ctrl_pkg::BR_LTU: cmp = rs1_data_i < rs2_data_i;
                        rv_ctrl_pkg::BR_GEU: cmp = rs1_data_i >= rs2_data_i;
                        default:             cmp = 1'b0; // no branch
                endcase
        end

        assign take_o = cmp | jump_i;

        // jal targets are even already, so clearing bit 0 only matters for jalr
        assign alu_result_o = jump_i ? {alu[XLEN-1:1], 1'b0} : alu;

endmodule

// File: src/rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile (
        input  logic                            clk,
        input  logic                            arst_n_i,
        input  logic [4:0]                      rs1_i,
        input  logic [4:0]                      rs2_i,
        input  logic [4:0]                      rd_i,
        input  logic                            wr_en_i,
        input  logic [rv_isa_pkg::XLEN-1:0]     wr_data_i,
        output logic [rv_isa_pkg::XLEN-1:0]     rs1_data_o,
        output logic [rv_isa_pkg::XLEN-1:0]     rs2_data_o
);
        logic [rv_isa_pkg::XLEN-1:0] regs [32];

        always_ff @(posedge clk or negedge arst_n_i) begin
                if (!arst_n_i) begin
                        for (int k = 0; k < 32; k++) begin
                                regs[k] <= '0;
                        end
                end else if (wr_en_i && rd_i != 5'd0) begin
                        regs[rd_i] <= wr_data_i;
                end
        end

        assign rs1_data_o = (rs1_i == 5'd0) ? '0 : regs[rs1_i]; // x0
        assign rs2_data_o = (rs2_i == 5'd0) ? '0 : regs[rs2_i];

endmodule

// File: src/rv_decode.sv
`timescale 1ns/1ps

module rv_decode (
        input  rv_isa_pkg::inst_u                    inst_i,
        output logic [4:0]                           rs1_o,
        output logic [4:0]                           rs2_o,
        output logic [4:0]                           rd_o,
        output logic signed [rv_isa_pkg::XLEN-1:0]   imm_o,
        output rv_ctrl_pkg::alu_op_e                 alu_op_o,
        output rv_ctrl_pkg::src_a_e                  src_a_o,
        output rv_ctrl_pkg::src_b_e                  src_b_o,
        output rv_ctrl_pkg::br_cond_e                br_cond_o,
        output logic                                 jump_o,
        output logic                                 mem_wr_o,
        output logic                                 reg_wr_o,
        output rv_ctrl_pkg::wb_sel_e                 wb_sel_o
);
        logic                   wr;     // before x0 mask
        logic                   alt;    // sub / sra select
        rv_ctrl_pkg::alu_op_e   alu_f3;

        assign rs1_o = inst_i.r.rs1;
        assign rs2_o = inst_i.r.rs2;
        assign rd_o  = inst_i.r.rd;

        // bit 30 picks sub only for register ops, sra for both
        assign alt = inst_i.r.funct7[5];

        always_comb begin
                case (inst_i.r.funct3)
                        rv_isa_pkg::F3_ADD_SUB: begin
                                if (inst_i.r.opcode == rv_isa_pkg::OP_OP && alt)
                                        alu_f3 = rv_ctrl_pkg::ALU_SUB;
                                else
                                        alu_f3 = rv_ctrl_pkg::ALU_ADD;
                        end
                        rv_isa_pkg::F3_SLL:  alu_f3 = rv_ctrl_pkg::ALU_SLL;
                        rv_isa_pkg::F3_SLT:  alu_f3 = rv_ctrl_pkg::ALU_SLT;
                        rv_isa_pkg::F3_SLTU: alu_f3 = rv_ctrl_pkg::ALU_SLTU;
                        rv_isa_pkg::F3_XOR:  alu_f3 = rv_ctrl_pkg::ALU_XOR;
                        rv_isa_pkg::F3_SR:   alu_f3 = alt ? rv_ctrl_pkg::ALU_SRA : rv_ctrl_pkg::ALU_SRL;
                        rv_isa_pkg::F3_OR:   alu_f3 = rv_ctrl_pkg::ALU_OR;
                        default:             alu_f3 = rv_ctrl_pkg::ALU_AND;
                endcase
        end

        always_comb begin
                imm_o     = '0;
                alu_op_o  = rv_ctrl_pkg::ALU_ADD;
                src_a_o   = rv_ctrl_pkg::SRC_A_RS1;
                src_b_o   = rv_ctrl_pkg::SRC_B_IMM;
                br_cond_o = rv_ctrl_pkg::BR_NONE;
                jump_o    = 1'b0;
                mem_wr_o  = 1'b0;
                wr        = 1'b0;
                wb_sel_o  = rv_ctrl_pkg::WB_ALU;
                case (inst_i.r.opcode)
                        rv_isa_pkg::OP_LUI: begin
                                imm_o    = {inst_i.u.imm, 12'b0};
                                alu_op_o = rv_ctrl_pkg::ALU_PASSB;
                                wr       = 1'b1;
                        end
                        rv_isa_pkg::OP_AUIPC: begin
                                imm_o   = {inst_i.u.imm, 12'b0};
                                src_a_o = rv_ctrl_pkg::SRC_A_PC;
                                wr      = 1'b1;
                        end
                        rv_isa_pkg::OP_JAL: begin
                                imm_o    = {{11{inst_i.j.imm20}}, inst_i.j.imm20,
                                            inst_i.j.imm19_12, inst_i.j.imm11,
                                            inst_i.j.imm10_1, 1'b0};
                                src_a_o  = rv_ctrl_pkg::SRC_A_PC;
                                jump_o   = 1'b1;
                                wr       = 1'b1;
                                wb_sel_o = rv_ctrl_pkg::WB_PC4;
                        end
                        rv_isa_pkg::OP_JALR: begin
                                imm_o    = {{20{inst_i.i.imm[11]}}, inst_i.i.imm};
                                jump_o   = 1'b1;
                                wr       = 1'b1;
                                wb_sel_o = rv_ctrl_pkg::WB_PC4;
                        end
                        rv_isa_pkg::OP_BRANCH: begin
                                imm_o   = {{19{inst_i.b.imm12}}, inst_i.b.imm12,
                                           inst_i.b.imm11, inst_i.b.imm10_5,
                                           inst_i.b.imm4_1, 1'b0};
                                src_a_o = rv_ctrl_pkg::SRC_A_PC; // alu forms the target
                                case (inst_i.b.funct3)
                                        rv_isa_pkg::F3_BEQ:  br_cond_o = rv_ctrl_pkg::BR_EQ;
                                        rv_isa_pkg::F3_BNE:  br_cond_o = rv_ctrl_pkg::BR_NE;
                                        rv_isa_pkg::F3_BLT:  br_cond_o = rv_ctrl_pkg::BR_LT;
                                        rv_isa_pkg::F3_BGE:  br_cond_o = rv_ctrl_pkg::BR_GE;
                                        rv_isa_pkg::F3_BLTU: br_cond_o = rv_ctrl_pkg::BR_LTU;
                                        rv_isa_pkg::F3_BGEU: br_cond_o = rv_ctrl_pkg::BR_GEU;
                                        default:             br_cond_o = rv_ctrl_pkg::BR_NONE;
                                endcase
                        end
                        rv_isa_pkg::OP_LOAD: begin
                                imm_o    = {{20{inst_i.i.imm[11]}}, inst_i.i.imm};
                                wr       = 1'b1;
                                wb_sel_o = rv_ctrl_pkg::WB_MEM;
                        end
                        rv_isa_pkg::OP_STORE: begin
                                imm_o    = {{20{inst_i.s.imm_hi[6]}}, inst_i.s.imm_hi,
                                            inst_i.s.imm_lo};
                                mem_wr_o = 1'b1;
                        end
                        rv_isa_pkg::OP_OPIMM: begin
                                imm_o    = {{20{inst_i.i.imm[11]}}, inst_i.i.imm};
                                alu_op_o = alu_f3;
                                wr       = 1'b1;
                        end
                        rv_isa_pkg::OP_OP: begin
                                src_b_o  = rv_ctrl_pkg::SRC_B_RS2;
                                alu_op_o = alu_f3;
                                wr       = 1'b1;
                        end
                        default: ; // nop
                endcase
        end

        assign reg_wr_o = wr && (inst_i.r.rd != 5'd0);

endmodule

// File: src/rv_ctrl_pkg.sv
package rv_ctrl_pkg;

        typedef enum logic [3:0] {
                ALU_ADD,
                ALU_SUB,
                ALU_AND,
                ALU_OR,
                ALU_XOR,
                ALU_SLT,
                ALU_SLTU,
                ALU_SLL,
                ALU_SRL,
                ALU_SRA,
                ALU_PASSB // lui
        } alu_op_e;

        typedef enum logic [2:0] {
                BR_NONE,
                BR_EQ,
                BR_NE,
                BR_LT,
                BR_GE,
                BR_LTU,
                BR_GEU
        } br_cond_e;

        typedef enum logic [1:0] {
                WB_ALU,
                WB_MEM,
                WB_PC4
        } wb_sel_e;

        typedef enum logic {
                SRC_A_RS1,
                SRC_A_PC
        } src_a_e;

        typedef enum logic {
                SRC_B_RS2,
                SRC_B_IMM
        } src_b_e;

endpackage

// File: src/rv_isa_pkg.sv
package rv_isa_pkg;

        localparam int XLEN = 32;

        localparam logic [6:0] OP_LUI    = 7'b0110111;
        localparam logic [6:0] OP_AUIPC  = 7'b0010111;
        localparam logic [6:0] OP_JAL    = 7'b1101111;
        localparam logic [6:0] OP_JALR   = 7'b1100111;
        localparam logic [6:0] OP_BRANCH = 7'b1100011;
        localparam logic [6:0] OP_LOAD   = 7'b0000011;
        localparam logic [6:0] OP_STORE  = 7'b0100011;
        localparam logic [6:0] OP_OPIMM  = 7'b0010011;
        localparam logic [6:0] OP_OP     = 7'b0110011;

        // alu funct3
        localparam logic [2:0] F3_ADD_SUB = 3'b000;
        localparam logic [2:0] F3_SLL     = 3'b001;
        localparam logic [2:0] F3_SLT     = 3'b010;
        localparam logic [2:0] F3_SLTU    = 3'b011;
        localparam logic [2:0] F3_XOR     = 3'b100;
        localparam logic [2:0] F3_SR      = 3'b101; // srl or sra by funct7[5]
        localparam logic [2:0] F3_OR      = 3'b110;
        localparam logic [2:0] F3_AND     = 3'b111;

        // branch funct3
        localparam logic [2:0] F3_BEQ  = 3'b000;
        localparam logic [2:0] F3_BNE  = 3'b001;
        localparam logic [2:0] F3_BLT  = 3'b100;
        localparam logic [2:0] F3_BGE  = 3'b101;
        localparam logic [2:0] F3_BLTU = 3'b110;
        localparam logic [2:0] F3_BGEU = 3'b111;

        typedef struct packed {
                logic [6:0] funct7;
                logic [4:0] rs2;
                logic [4:0] rs1;
                logic [2:0] funct3;
                logic [4:0] rd;
                logic [6:0] opcode;
        } r_fmt_t;

        typedef struct packed {
                logic [11:0] imm;
                logic [4:0]  rs1;
                logic [2:0]  funct3;
                logic [4:0]  rd;
                logic [6:0]  opcode;
        } i_fmt_t;

        typedef struct packed {
                logic [6:0] imm_hi;
                logic [4:0] rs2;
                logic [4:0] rs1;
                logic [2:0] funct3;
                logic [4:0] imm_lo;
                logic [6:0] opcode;
        } s_fmt_t;

        typedef struct packed {
                logic       imm12;
                logic [5:0] imm10_5;
                logic [4:0] rs2;
                logic [4:0] rs1;
                logic [2:0] funct3;
                logic [3:0] imm4_1;
                logic       imm11;
                logic [6:0] opcode;
        } b_fmt_t;

        typedef struct packed {
                logic [19:0] imm;
                logic [4:0]  rd;
                logic [6:0]  opcode;
        } u_fmt_t;

        typedef struct packed {
                logic       imm20;
                logic [9:0] imm10_1;
                logic       imm11;
                logic [7:0] imm19_12;
                logic [4:0] rd;
                logic [6:0] opcode;
        } j_fmt_t;

        typedef union packed {
                r_fmt_t r;
                i_fmt_t i;
                s_fmt_t s;
                b_fmt_t b;
                u_fmt_t u;
                j_fmt_t j;
        } inst_u;

endpackage
